//--- design/werewolf_pkg.sv
package werewolf_pkg;

    // ----------------------------------------------------------------------
    // Game sizes
    // ----------------------------------------------------------------------
    localparam int NUM_PLAYERS = 5;
    localparam int PLAYER_W    = 3;              // Player index width
    localparam int NUM_DEALS   = 20;
    localparam int DEAL_W      = 5;              // Deal index width
    localparam int ROLE_W      = 2;              // One role slot
    localparam int DEAL_BITS   = NUM_PLAYERS * ROLE_W;
    localparam int STATE_W     = 5;              // Also the display code width

    // Role slot encoding
    typedef enum logic [ROLE_W-1:0] {
        ROLE_VILLAGER = 2'd0,
        ROLE_WOLF     = 2'd1,
        ROLE_DOCTOR   = 2'd2,
        ROLE_HIDDEN   = 2'd3
    } role_t;

    // Game FSM states, codes go straight to the state display
    typedef enum logic [STATE_W-1:0] {
        ST_IDLE        = 5'd0,
        ST_CLEAR       = 5'd1,
        ST_SHUFFLE     = 5'd2,
        ST_STORE       = 5'd3,
        ST_SETTLE      = 5'd4,
        ST_NIGHT_START = 5'd5,
        ST_NEXT_PLAYER = 5'd6,
        ST_TURN        = 5'd7,
        ST_NIGHT_DONE  = 5'd8,
        ST_WAIT_PASS   = 5'd9
    } game_state_t;

    // ----------------------------------------------------------------------
    // Deal table, player 0 in the top slot
    // Wolf at k/4, doctor at the (k mod 4)-th non-wolf player
    // ----------------------------------------------------------------------
    localparam logic [DEAL_BITS-1:0] DEAL_TABLE [NUM_DEALS] = '{
        10'b01_10_00_00_00,  // 0  W0 D1
        10'b01_00_10_00_00,  // 1  W0 D2
        10'b01_00_00_10_00,  // 2  W0 D3
        10'b01_00_00_00_10,  // 3  W0 D4
        10'b10_01_00_00_00,  // 4  W1 D0
        10'b00_01_10_00_00,  // 5  W1 D2
        10'b00_01_00_10_00,  // 6  W1 D3
        10'b00_01_00_00_10,  // 7  W1 D4
        10'b10_00_01_00_00,  // 8  W2 D0
        10'b00_10_01_00_00,  // 9  W2 D1
        10'b00_00_01_10_00,  // 10 W2 D3
        10'b00_00_01_00_10,  // 11 W2 D4
        10'b10_00_00_01_00,  // 12 W3 D0
        10'b00_10_00_01_00,  // 13 W3 D1
        10'b00_00_10_01_00,  // 14 W3 D2
        10'b00_00_00_01_10,  // 15 W3 D4
        10'b10_00_00_00_01,  // 16 W4 D0
        10'b00_10_00_00_01,  // 17 W4 D1
        10'b00_00_10_00_01,  // 18 W4 D2
        10'b00_00_00_10_01   // 19 W4 D3
    };

endpackage

//--- design/segment_decoder.sv
`timescale 1ns/1ps

module segment_decoder
    import werewolf_pkg::*;
(
    input  logic [STATE_W-1:0] code,
    output logic [6:0]         segments  // Active low, bit 6 is g
);

    // Segment map
    //     a(0)
    //  f(5)  b(1)
    //     g(6)
    //  e(4)  c(2)
    //     d(3)

    always_comb begin
        case (code)
            // --------------------------------------------------------------
            // Hex digits
            // --------------------------------------------------------------
            5'd0:  segments = 7'b1000000;
            5'd1:  segments = 7'b1111001;
            5'd2:  segments = 7'b0100100;
            5'd3:  segments = 7'b0110000;
            5'd4:  segments = 7'b0011001;
            5'd5:  segments = 7'b0010010;
            5'd6:  segments = 7'b0000010;
            5'd7:  segments = 7'b1111000;
            5'd8:  segments = 7'b0000000;
            5'd9:  segments = 7'b0010000;
            5'd10: segments = 7'b0001000;  // A
            5'd11: segments = 7'b0000011;  // b
            5'd12: segments = 7'b1000110;  // C
            5'd13: segments = 7'b0100001;  // d
            5'd14: segments = 7'b0000110;  // E
            5'd15: segments = 7'b0001110;  // F
            // --------------------------------------------------------------
            // Upper range, one segment each
            // --------------------------------------------------------------
            5'd16: segments = 7'b1111110;  // a
            5'd17: segments = 7'b1111101;  // b
            5'd18: segments = 7'b1111011;  // c
            5'd19: segments = 7'b1110111;  // d
            5'd20: segments = 7'b1101111;  // e
            5'd21: segments = 7'b1011111;  // f
            5'd22: segments = 7'b0111111;  // g
            // Then segment pairs
            5'd23: segments = 7'b1111100;  // a b
            5'd24: segments = 7'b1110011;  // c d
            5'd25: segments = 7'b1100111;  // d e
            5'd26: segments = 7'b1001111;  // e f
            5'd27: segments = 7'b1011110;  // f a
            5'd28: segments = 7'b0111110;  // a g
            5'd29: segments = 7'b0110111;  // g d
            5'd30: segments = 7'b0111101;  // b g
            5'd31: segments = 7'b0101111;  // e g
            default: segments = 7'b1111111;
        endcase
    end

endmodule

//--- design/game_control.sv
`timescale 1ns/1ps

module game_control
    import werewolf_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        play,         // Level, sampled as is
    input  logic        pass,         // Level, edge detected here
    input  logic        last_player,
    output logic        clear_game,
    output logic        shuffle,
    output logic        store_deal,
    output logic        clear_player,
    output logic        next_player,
    output logic        reveal,
    output game_state_t state
);

    logic        pass_q0;             // First sample of pass
    logic        pass_q1;             // Delayed sample
    logic        pass_pulse;
    game_state_t state_q;
    game_state_t state_d;

    // ----------------------------------------------------------------------
    // Pass edge detector
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pass_q0 <= 1'b0;
            pass_q1 <= 1'b0;
        end else begin
            pass_q0 <= pass;
            pass_q1 <= pass_q0;
        end
    end

    // High for one cycle after pass rises
    assign pass_pulse = pass_q0 & ~pass_q1;

    // ----------------------------------------------------------------------
    // State register
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (play) begin
                    state_d = ST_CLEAR;
                end
            end
            ST_CLEAR:       state_d = ST_SHUFFLE;
            ST_SHUFFLE: begin
                // Host passes to freeze the deal
                if (pass_pulse) begin
                    state_d = ST_STORE;
                end
            end
            ST_STORE:       state_d = ST_SETTLE;     // Deal register loads
            ST_SETTLE:      state_d = ST_NIGHT_START;
            ST_NIGHT_START: state_d = ST_TURN;       // Player counter cleared
            ST_TURN: begin
                if (pass_pulse) begin
                    state_d = last_player ? ST_NIGHT_DONE : ST_NEXT_PLAYER;
                end
            end
            ST_NEXT_PLAYER: state_d = ST_WAIT_PASS;
            ST_WAIT_PASS: begin
                // Role stays hidden until the next player is ready
                if (pass_pulse) begin
                    state_d = ST_TURN;
                end
            end
            ST_NIGHT_DONE:  state_d = ST_NIGHT_DONE; // Held until reset
            default:        state_d = ST_IDLE;       // Unused codes
        endcase
    end

    // ----------------------------------------------------------------------
    // Moore strobes
    // ----------------------------------------------------------------------
    always_comb begin
        clear_game   = (state_q == ST_IDLE) || (state_q == ST_CLEAR);
        shuffle      = (state_q == ST_SHUFFLE);
        store_deal   = (state_q == ST_STORE);
        clear_player = (state_q == ST_IDLE) || (state_q == ST_CLEAR)
                    || (state_q == ST_NIGHT_START);
        next_player  = (state_q == ST_NEXT_PLAYER);
        reveal       = (state_q == ST_TURN);
    end

    assign state = state_q;

endmodule

//--- design/deal_datapath.sv
`timescale 1ns/1ps

module deal_datapath
    import werewolf_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 clear_game,
    input  logic                 shuffle,
    input  logic                 store_deal,
    input  logic                 clear_player,
    input  logic                 next_player,
    output logic [DEAL_W-1:0]    deal_index,
    output logic [DEAL_BITS-1:0] deal,
    output logic [PLAYER_W-1:0]  player,
    output logic                 last_player
);

    logic [DEAL_W-1:0]    deal_count;   // Free-running while shuffling
    logic [DEAL_W-1:0]    read_index;   // Index of the word in read_word
    logic [DEAL_BITS-1:0] read_word;
    logic [DEAL_BITS-1:0] deal_q;
    logic [PLAYER_W-1:0]  player_q;

    // ----------------------------------------------------------------------
    // Deal counter, modulo NUM_DEALS
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            deal_count <= '0;
        end else if (clear_game) begin
            deal_count <= '0;
        end else if (shuffle) begin
            if (deal_count == DEAL_W'(NUM_DEALS - 1)) begin
                deal_count <= '0;
            end else begin
                deal_count <= deal_count + 1'b1;
            end
        end
    end

    // Table read, tracks the counter while shuffling
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            read_index <= '0;
        end else if (clear_game) begin
            read_index <= '0;
        end else if (shuffle) begin
            read_index <= deal_count;
        end
    end

    always_ff @(posedge clock) begin
        if (shuffle) begin
            read_word <= DEAL_TABLE[deal_count];
        end
    end

    // Latched deal for the night
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            deal_q <= '0;
        end else if (clear_game) begin
            deal_q <= '0;
        end else if (store_deal) begin
            deal_q <= read_word;               // Word frozen one cycle earlier
        end
    end

    // ----------------------------------------------------------------------
    // Player counter
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            player_q <= '0;
        end else if (clear_player) begin
            player_q <= '0;
        end else if (next_player) begin
            if (last_player) begin
                player_q <= '0;                // Wrap, not reached in play
            end else begin
                player_q <= player_q + 1'b1;
            end
        end
    end

    assign last_player = (player_q == PLAYER_W'(NUM_PLAYERS - 1));
    assign deal_index  = read_index;
    assign deal        = deal_q;
    assign player      = player_q;

endmodule

//--- design/role_lookup.sv
`timescale 1ns/1ps

module role_lookup
    import werewolf_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic [PLAYER_W-1:0]  player,
    input  logic [DEAL_BITS-1:0] deal,
    input  logic                 reveal,
    output role_t                role
);

    role_t role_d;
    role_t role_q;

    // Slot of the current player, player 0 at the top
    always_comb begin
        int slot_lsb;
        slot_lsb = 0;
        role_d   = ROLE_HIDDEN;                // Index out of range
        if (int'(player) < NUM_PLAYERS) begin
            slot_lsb = ROLE_W * (NUM_PLAYERS - 1 - int'(player));
            role_d   = role_t'(deal[slot_lsb +: ROLE_W]);
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            role_q <= ROLE_HIDDEN;
        end else begin
            role_q <= role_d;                  // One cycle behind player
        end
    end

    // Shown only during a turn
    assign role = reveal ? role_q : ROLE_HIDDEN;

endmodule

//--- design/werewolf_dealer.sv
`timescale 1ns/1ps

module werewolf_dealer
    import werewolf_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    input  logic                play,
    input  logic                pass,
    output role_t               role,
    output logic [PLAYER_W-1:0] player,
    output logic [DEAL_W-1:0]   deal_index,
    output game_state_t         state,
    output logic                night_done,
    output logic [6:0]          role_segments,
    output logic [6:0]          player_segments,
    output logic [6:0]          deal_segments,
    output logic [6:0]          state_segments
);

    logic                 clear_game;
    logic                 shuffle;
    logic                 store_deal;
    logic                 clear_player;
    logic                 next_player;
    logic                 reveal;
    logic                 last_player;
    logic [DEAL_BITS-1:0] deal;

    // ----------------------------------------------------------------------
    // Control, datapath and role result
    // ----------------------------------------------------------------------
    game_control u_game_control (
        .clock        (clock),
        .reset        (reset),
        .play         (play),
        .pass         (pass),
        .last_player  (last_player),
        .clear_game   (clear_game),
        .shuffle      (shuffle),
        .store_deal   (store_deal),
        .clear_player (clear_player),
        .next_player  (next_player),
        .reveal       (reveal),
        .state        (state)
    );

    deal_datapath u_deal_datapath (
        .clock        (clock),
        .reset        (reset),
        .clear_game   (clear_game),
        .shuffle      (shuffle),
        .store_deal   (store_deal),
        .clear_player (clear_player),
        .next_player  (next_player),
        .deal_index   (deal_index),
        .deal         (deal),
        .player       (player),
        .last_player  (last_player)
    );

    role_lookup u_role_lookup (
        .clock  (clock),
        .reset  (reset),
        .player (player),
        .deal   (deal),
        .reveal (reveal),
        .role   (role)
    );

    assign night_done = (state == ST_NIGHT_DONE);

    // ----------------------------------------------------------------------
    // Displays, codes zero extended to five bits
    // ----------------------------------------------------------------------
    segment_decoder u_role_display (
        .code     ({{(STATE_W - ROLE_W){1'b0}}, role}),
        .segments (role_segments)
    );

    segment_decoder u_player_display (
        .code     ({{(STATE_W - PLAYER_W){1'b0}}, player}),
        .segments (player_segments)
    );

    segment_decoder u_deal_display (
        .code     (deal_index),
        .segments (deal_segments)
    );

    segment_decoder u_state_display (
        .code     (state),     // State codes 0 to 9
        .segments (state_segments)
    );

endmodule

//--- testbench/werewolf_tb.sv
`timescale 1ns/1ps

module werewolf_tb
    import werewolf_pkg::*;
();

    localparam int NUM_GAMES   = 6;
    localparam int HOLD_CYCLES = 10;     // Cycles watched in night done

    // Hex glyphs, active low, bit 6 is segment g
    localparam logic [6:0] GLYPHS [16] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
        7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
    };

    logic                clock;
    logic                reset;
    logic                play;
    logic                pass;
    role_t               role;
    logic [PLAYER_W-1:0] player;
    logic [DEAL_W-1:0]   deal_index;
    game_state_t         state;
    logic                night_done;
    logic [6:0]          role_segments;
    logic [6:0]          player_segments;
    logic [6:0]          deal_segments;
    logic [6:0]          state_segments;

    // Game table, cycles from play to pass and the deal it must give
    int gaps [NUM_GAMES];
    int expected_index [NUM_GAMES];
    int cycle_count = 0;
    int cycle_limit;

    werewolf_dealer dut (
        .clock           (clock),
        .reset           (reset),
        .play            (play),
        .pass            (pass),
        .role            (role),
        .player          (player),
        .deal_index      (deal_index),
        .state           (state),
        .night_done      (night_done),
        .role_segments   (role_segments),
        .player_segments (player_segments),
        .deal_segments   (deal_segments),
        .state_segments  (state_segments)
    );

    always #4 clock = ~clock;            // 8 ns period

    // ----------------------------------------------------------------------
    // Run length guard
    // ----------------------------------------------------------------------
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT never reached the awaited state",
                     cycle_count);
            $display("Finished with errors");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Role of player p in deal k
    function automatic int rule_role(input int k, input int p);
        int wolf;
        int doctor;
        wolf   = k / 4;
        doctor = k % 4;                  // Counted among the non-wolves
        if (doctor >= wolf) begin
            doctor = doctor + 1;
        end
        if (p == wolf) begin
            return int'(ROLE_WOLF);
        end
        if (p == doctor) begin
            return int'(ROLE_DOCTOR);
        end
        return int'(ROLE_VILLAGER);
    endfunction

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    // Polls at the falling edge, the cycle counter bounds it
    task automatic wait_for_state(input game_state_t target);
        @(negedge clock);
        while (state != target) begin
            @(negedge clock);
        end
    endtask

    // ----------------------------------------------------------------------
    // One full game, reset to night done
    // ----------------------------------------------------------------------
    task automatic run_game(input int g);
        int k;
        k = expected_index[g];
        @(posedge clock);
        reset <= 1'b1;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        play  <= 1'b1;                   // Edge a
        @(negedge clock);
        check_value("state", int'(state), int'(ST_IDLE));
        check_value("state_segments", int'(state_segments), int'(GLYPHS[int'(ST_IDLE)]));
        check_value("role", int'(role), int'(ROLE_HIDDEN));
        check_value("player", int'(player), 0);
        check_value("deal_index", int'(deal_index), 0);
        check_value("deal_segments", int'(deal_segments), int'(GLYPHS[0]));
        check_value("night_done", int'(night_done), 0);
        @(posedge clock);
        play <= 1'b0;
        repeat (gaps[g] - 1) @(posedge clock);
        pass <= 1'b1;                    // Edge b, freezes the deal
        @(posedge clock);
        pass <= 1'b0;

        for (int p = 0; p < NUM_PLAYERS; p++) begin
            wait_for_state(ST_TURN);
            @(posedge clock);
            pass <= 1'b1;                // Acted on two edges later
            @(negedge clock);
            check_value("deal_index", int'(deal_index), k);
            if (k < 16) begin
                check_value("deal_segments", int'(deal_segments), int'(GLYPHS[k]));
            end
            check_value("state_segments", int'(state_segments),
                        int'(GLYPHS[int'(ST_TURN)]));
            check_value("player", int'(player), p);
            check_value("role", int'(role), rule_role(k, p));
            check_value("role_segments", int'(role_segments),
                        int'(GLYPHS[rule_role(k, p)]));
            @(posedge clock);
            pass <= 1'b0;
            if (p < NUM_PLAYERS - 1) begin
                wait_for_state(ST_WAIT_PASS);
                check_value("role", int'(role), int'(ROLE_HIDDEN));
                check_value("player_segments", int'(player_segments), int'(GLYPHS[p + 1]));
                check_value("state_segments", int'(state_segments),
                            int'(GLYPHS[int'(ST_WAIT_PASS)]));
                @(posedge clock);
                pass <= 1'b1;
                @(posedge clock);
                pass <= 1'b0;
            end
        end

        wait_for_state(ST_NIGHT_DONE);
        repeat (HOLD_CYCLES) begin
            @(posedge clock);
            pass <= ~pass;               // Extra pulses, ignored
            @(negedge clock);
            check_value("state", int'(state), int'(ST_NIGHT_DONE));
            check_value("state_segments", int'(state_segments),
                        int'(GLYPHS[int'(ST_NIGHT_DONE)]));
            check_value("night_done", int'(night_done), 1);
        end
    endtask

    initial begin
        logic [31:0] seed;
        int          total_gap;
        clock = 1'b0;
        reset = 1'b1;
        play  = 1'b0;
        pass  = 1'b0;
        seed  = 32'hb790;

        // Fixed gaps, shortest legal and two that wrap
        gaps[0] = 3;
        gaps[1] = 22;
        gaps[2] = 40;
        for (int g = 3; g < NUM_GAMES; g++) begin
            seed    = xorshift(seed);
            gaps[g] = 3 + int'(seed % 32'd40);
        end
        total_gap = 0;
        for (int g = 0; g < NUM_GAMES; g++) begin
            expected_index[g] = (gaps[g] - 1) % NUM_DEALS;
            total_gap         = total_gap + gaps[g];
        end
        cycle_limit = total_gap + 60 * NUM_GAMES;

        for (int g = 0; g < NUM_GAMES; g++) begin
            run_game(g);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- files.f
design/werewolf_pkg.sv
design/segment_decoder.sv
design/game_control.sv
design/deal_datapath.sv
design/role_lookup.sv
design/werewolf_dealer.sv
testbench/werewolf_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = werewolf_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
